// File: dcache_l1_macros.svh
// Cache geometry and derived address field widths for the L1 data cache
`ifndef DCACHE_L1_MACROS_SVH
`define DCACHE_L1_MACROS_SVH

// Base geometry, all powers of two
`define DCACHE_WAYS        2
`define DCACHE_SETS        16
`define DCACHE_LINE_WORDS  4
`define DCACHE_ADDR_W      32
`define DCACHE_WORD_W      32

// Derived widths
`define DCACHE_BE_W        (`DCACHE_WORD_W / 8)
`define DCACHE_BYTE_OFF_W  $clog2(`DCACHE_BE_W)
`define DCACHE_WORD_OFF_W  $clog2(`DCACHE_LINE_WORDS)
`define DCACHE_SET_W       $clog2(`DCACHE_SETS)
`define DCACHE_WAY_IDX_W   $clog2(`DCACHE_WAYS)
`define DCACHE_LINE_OFF_W  (`DCACHE_WORD_OFF_W + `DCACHE_BYTE_OFF_W)
`define DCACHE_TAG_W       (`DCACHE_ADDR_W - `DCACHE_SET_W - `DCACHE_LINE_OFF_W)
`define DCACHE_LINE_ADDR_W (`DCACHE_ADDR_W - `DCACHE_LINE_OFF_W)

`endif

// File: dcache_l1_pkg.sv
// Shared data, address and request types of the L1 data cache
`include "dcache_l1_macros.svh"

package dcache_l1_pkg;

  // Data words and lines
  typedef logic [`DCACHE_WORD_W-1:0] word_t;
  typedef logic [`DCACHE_BE_W-1:0] be_t;
  typedef word_t [`DCACHE_LINE_WORDS-1:0] line_t;

  // Address pieces
  typedef logic [`DCACHE_TAG_W-1:0] tag_t;
  typedef logic [`DCACHE_SET_W-1:0] set_idx_t;
  typedef logic [`DCACHE_WORD_OFF_W-1:0] word_off_t;
  typedef logic [`DCACHE_LINE_ADDR_W-1:0] line_addr_t;

  // One bit per way, one bit per word of a line
  typedef logic [`DCACHE_WAYS-1:0] way_vec_t;
  typedef logic [`DCACHE_LINE_WORDS-1:0] word_vec_t;

  // Tag compare view
  typedef struct packed {
    tag_t                          tag;
    set_idx_t                      idx;
    word_off_t                     word;
    logic [`DCACHE_BYTE_OFF_W-1:0] byte_off;
  } paddr_fields_t;

  // MSHR and wake-up view
  typedef struct packed {
    line_addr_t                    line_addr;
    logic [`DCACHE_LINE_OFF_W-1:0] line_off;
  } paddr_line_t;

  // Same physical address, two decodings
  typedef union packed {
    paddr_fields_t fields;
    paddr_line_t   line;
  } paddr_u;

  // Winner of the d0 schedule
  typedef enum logic [2:0] {
    Idle,
    Init,
    D1Store,
    Refill,
    LsqLoad,
    LsqStore
  } d0_req_e;

endpackage

// File: dcache_way_sram.sv
// One cache way with tag plus valid array and word-writable data array
`timescale 1ns/1ps
`include "dcache_l1_macros.svh"

module dcache_way_sram (
  input  logic                     clk_i,
  input  dcache_l1_pkg::set_idx_t  addr_i,
  input  logic                     tag_we_i,
  input  dcache_l1_pkg::tag_t      wtag_i,
  input  logic                     wvalid_i,
  input  dcache_l1_pkg::word_vec_t data_we_i,
  input  dcache_l1_pkg::line_t     wline_i,
  output dcache_l1_pkg::tag_t      rtag_o,
  output logic                     rvalid_o,
  output dcache_l1_pkg::line_t     rline_o
);

  // Valid bit sits above the tag
  logic [`DCACHE_TAG_W:0] tag_mem  [`DCACHE_SETS];
  dcache_l1_pkg::line_t   data_mem [`DCACHE_SETS];

  // Tag array, read returns the old entry on a same-edge write
  always_ff @(posedge clk_i) begin
    if (tag_we_i) begin
      tag_mem[addr_i] <= {wvalid_i, wtag_i};
    end
    {rvalid_o, rtag_o} <= tag_mem[addr_i];
  end

  // Data array with one enable per word
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < `DCACHE_LINE_WORDS; w++) begin
      if (data_we_i[w]) begin
        data_mem[addr_i][w] <= wline_i[w];
      end
    end
    rline_o <= data_mem[addr_i];
  end

endmodule

// File: dcache_d0_decode.sv
// d0 fixed-priority scheduler, request encoder, init sweep counter and ready levels
`timescale 1ns/1ps

module dcache_d0_decode (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    lsq_valid_i,
  input  logic                    lsq_store_i,
  input  logic                    l2c_valid_i,
  input  logic                    d1_st_valid_i,
  input  logic                    mshr_busy_i,
  output logic                    lsq_rdy_o,
  output logic                    l2c_rdy_o,
  output logic                    init_done_o,
  output dcache_l1_pkg::set_idx_t init_idx_o,
  output dcache_l1_pkg::d0_req_e  req_type_o
);

  logic                    init_busy_q;
  dcache_l1_pkg::set_idx_t init_idx_q;
  logic                    lsq_slot;

  // Sweep one set per cycle after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      init_busy_q <= 1'b1;
      init_idx_q  <= '0;
    end else if (init_busy_q) begin
      init_idx_q <= init_idx_q + 1'b1;
      // Last set reached
      if (&init_idx_q) begin
        init_busy_q <= 1'b0;
      end
    end
  end

  assign init_idx_o  = init_idx_q;
  assign init_done_o = ~init_busy_q;

  // Priority: init, d1 write-back, refill, LSQ
  always_comb begin
    if (init_busy_q) begin
      req_type_o = dcache_l1_pkg::Init;
    end else if (d1_st_valid_i) begin
      req_type_o = dcache_l1_pkg::D1Store;
    end else if (l2c_valid_i) begin
      req_type_o = dcache_l1_pkg::Refill;
    end else if (lsq_valid_i && !mshr_busy_i) begin
      req_type_o = lsq_store_i ? dcache_l1_pkg::LsqStore : dcache_l1_pkg::LsqLoad;
    end else begin
      req_type_o = dcache_l1_pkg::Idle;
    end
  end

  // Slot left free for the LSQ by the higher requesters
  assign lsq_slot = (req_type_o == dcache_l1_pkg::Idle)    ||
                    (req_type_o == dcache_l1_pkg::LsqLoad) ||
                    (req_type_o == dcache_l1_pkg::LsqStore);

  // Refill only loses to init and d1
  assign l2c_rdy_o = (req_type_o != dcache_l1_pkg::Init) &&
                     (req_type_o != dcache_l1_pkg::D1Store);

  // One outstanding miss at a time
  assign lsq_rdy_o = lsq_slot && !mshr_busy_i;

endmodule

// File: dcache_d0_execute.sv
// d0 address and per-way write controls, d0 to d1 request register and LSQ wake-up
`timescale 1ns/1ps
`include "dcache_l1_macros.svh"

module dcache_d0_execute (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        clr_i,
  input  dcache_l1_pkg::d0_req_e                      req_type_i,
  input  dcache_l1_pkg::set_idx_t                     init_idx_i,
  input  dcache_l1_pkg::paddr_u                       lsq_addr_i,
  input  dcache_l1_pkg::word_t                        lsq_wdata_i,
  input  dcache_l1_pkg::be_t                          lsq_be_i,
  input  dcache_l1_pkg::line_addr_t                   l2c_line_addr_i,
  input  dcache_l1_pkg::line_t                        l2c_line_i,
  input  dcache_l1_pkg::set_idx_t                     d1_st_addr_i,
  input  dcache_l1_pkg::way_vec_t                     d1_st_way_i,
  input  dcache_l1_pkg::line_t                        d1_st_line_i,
  input  dcache_l1_pkg::word_vec_t                    d1_st_wen_words_i,
  input  dcache_l1_pkg::way_vec_t                     victim_i,
  output dcache_l1_pkg::set_idx_t                     mem_addr_o,
  output dcache_l1_pkg::way_vec_t                     tag_we_o,
  output dcache_l1_pkg::tag_t                         wtag_o,
  output logic                                        wvalid_o,
  output dcache_l1_pkg::word_vec_t [`DCACHE_WAYS-1:0] data_we_o,
  output dcache_l1_pkg::line_t                        wline_o,
  output dcache_l1_pkg::d0_req_e                      d1_req_o,
  output dcache_l1_pkg::paddr_u                       d1_addr_o,
  output dcache_l1_pkg::word_t                        d1_wdata_o,
  output dcache_l1_pkg::be_t                          d1_be_o,
  output logic                                        wup_valid_o,
  output dcache_l1_pkg::line_addr_t                   wup_line_o
);

  dcache_l1_pkg::paddr_u refill_addr;
  logic                  lsq_win;

  // Refill line address seen through the field view
  always_comb begin
    refill_addr                = '0;
    refill_addr.line.line_addr = l2c_line_addr_i;
  end

  // Shared address and per-way write enables
  always_comb begin
    mem_addr_o = lsq_addr_i.fields.idx;
    tag_we_o   = '0;
    wtag_o     = refill_addr.fields.tag;
    wvalid_o   = 1'b0;
    data_we_o  = '0;
    wline_o    = l2c_line_i;
    case (req_type_i)
      // All ways of one set invalid
      dcache_l1_pkg::Init: begin
        mem_addr_o = init_idx_i;
        tag_we_o   = '1;
        wtag_o     = '0;
      end
      // Whole line and tag into the victim
      dcache_l1_pkg::Refill: begin
        mem_addr_o = refill_addr.fields.idx;
        tag_we_o   = victim_i;
        wvalid_o   = 1'b1;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
          data_we_o[w] = {`DCACHE_LINE_WORDS{victim_i[w]}};
        end
      end
      // Merged line from d1, only the stored word enabled
      dcache_l1_pkg::D1Store: begin
        mem_addr_o = d1_st_addr_i;
        wline_o    = d1_st_line_i;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
          data_we_o[w] = d1_st_way_i[w] ? d1_st_wen_words_i : '0;
        end
      end
      // LSQ reads and idle cycles write nothing
      default: begin
      end
    endcase
  end

  assign lsq_win = (req_type_i == dcache_l1_pkg::LsqLoad) ||
                   (req_type_i == dcache_l1_pkg::LsqStore);

  // Request type to d1, idle unless the LSQ won
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      d1_req_o <= dcache_l1_pkg::Idle;
    end else if (clr_i || !lsq_win) begin
      d1_req_o <= dcache_l1_pkg::Idle;
    end else begin
      d1_req_o <= req_type_i;
    end
  end

  // Request payload
  always_ff @(posedge clk_i) begin
    if (lsq_win) begin
      d1_addr_o  <= lsq_addr_i;
      d1_wdata_o <= lsq_wdata_i;
      d1_be_o    <= lsq_be_i;
    end
  end

  // Wake-up in the refill write cycle
  assign wup_valid_o = (req_type_i == dcache_l1_pkg::Refill);
  assign wup_line_o  = l2c_line_addr_i;

endmodule

// File: dcache_d1_result.sv
// d1 tag compare, load select, store merge, single MSHR, victim choice and responses
`timescale 1ns/1ps
`include "dcache_l1_macros.svh"

module dcache_d1_result (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    clr_i,
  input  dcache_l1_pkg::d0_req_e                  d1_req_i,
  input  dcache_l1_pkg::paddr_u                   d1_addr_i,
  input  dcache_l1_pkg::word_t                    d1_wdata_i,
  input  dcache_l1_pkg::be_t                      d1_be_i,
  input  dcache_l1_pkg::tag_t  [`DCACHE_WAYS-1:0] way_tag_i,
  input  dcache_l1_pkg::way_vec_t                 way_valid_i,
  input  dcache_l1_pkg::line_t [`DCACHE_WAYS-1:0] way_line_i,
  input  logic                                    wup_valid_i,
  output logic                                    d1_st_valid_o,
  output dcache_l1_pkg::set_idx_t                 d1_st_addr_o,
  output dcache_l1_pkg::way_vec_t                 d1_st_way_o,
  output dcache_l1_pkg::line_t                    d1_st_line_o,
  output dcache_l1_pkg::word_vec_t                d1_st_wen_words_o,
  output logic                                    mshr_busy_o,
  output dcache_l1_pkg::way_vec_t                 victim_o,
  output logic                                    resp_valid_o,
  output logic                                    resp_store_o,
  output logic                                    resp_hit_o,
  output dcache_l1_pkg::word_t                    resp_data_o,
  output logic                                    miss_valid_o,
  output dcache_l1_pkg::line_addr_t               miss_line_o
);

  dcache_l1_pkg::way_vec_t       hit_vec;
  dcache_l1_pkg::line_t          hit_line;
  dcache_l1_pkg::line_t          merged_line;
  logic                          hit;
  logic                          is_load;
  logic                          is_store;
  logic                          load_miss;
  logic [`DCACHE_WAY_IDX_W-1:0]  victim_idx;
  logic [`DCACHE_WAY_IDX_W-1:0]  rr_q [`DCACHE_SETS];
  logic                          mshr_valid_q;
  dcache_l1_pkg::line_addr_t     mshr_line_q;
  dcache_l1_pkg::paddr_u         mshr_addr;

  assign is_load  = (d1_req_i == dcache_l1_pkg::LsqLoad);
  assign is_store = (d1_req_i == dcache_l1_pkg::LsqStore);

  // Tag compare, hit line by one-hot OR
  always_comb begin
    hit_vec  = '0;
    hit_line = '0;
    for (int w = 0; w < `DCACHE_WAYS; w++) begin
      hit_vec[w] = way_valid_i[w] && (way_tag_i[w] == d1_addr_i.fields.tag);
      if (hit_vec[w]) begin
        hit_line = hit_line | way_line_i[w];
      end
    end
  end

  assign hit       = |hit_vec;
  assign load_miss = is_load && !hit;

  // Byte merge of the store word
  always_comb begin
    merged_line = hit_line;
    for (int b = 0; b < `DCACHE_BE_W; b++) begin
      if (d1_be_i[b]) begin
        merged_line[d1_addr_i.fields.word][8*b +: 8] = d1_wdata_i[8*b +: 8];
      end
    end
  end

  // Write-back request, store misses write nothing
  assign d1_st_valid_o     = is_store && hit && !clr_i;
  assign d1_st_addr_o      = d1_addr_i.fields.idx;
  assign d1_st_way_o       = hit_vec;
  assign d1_st_line_o      = merged_line;
  assign d1_st_wen_words_o = dcache_l1_pkg::word_vec_t'(1) << d1_addr_i.fields.word;

  // Lowest invalid way, else round-robin pointer of the set
  always_comb begin
    victim_idx = rr_q[d1_addr_i.fields.idx];
    for (int w = `DCACHE_WAYS - 1; w >= 0; w--) begin
      if (!way_valid_i[w]) begin
        victim_idx = w[`DCACHE_WAY_IDX_W-1:0];
      end
    end
  end

  // Miss in flight already blocks the LSQ
  assign mshr_busy_o = mshr_valid_q || load_miss;

  // MSHR state and held victim
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mshr_valid_q <= 1'b0;
      victim_o     <= '0;
    end else if (clr_i) begin
      mshr_valid_q <= 1'b0;
    end else if (load_miss) begin
      mshr_valid_q <= 1'b1;
      victim_o     <= dcache_l1_pkg::way_vec_t'(1) << victim_idx;
    end else if (wup_valid_i) begin
      mshr_valid_q <= 1'b0;
    end
  end

  // Missed line, also the miss strobe payload
  always_ff @(posedge clk_i) begin
    if (load_miss) begin
      mshr_line_q <= d1_addr_i.line.line_addr;
    end
  end

  assign miss_line_o = mshr_line_q;

  // Set of the pending line
  always_comb begin
    mshr_addr                = '0;
    mshr_addr.line.line_addr = mshr_line_q;
  end

  // Pointer of the refilled set advances on each refill
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < `DCACHE_SETS; s++) begin
        rr_q[s] <= '0;
      end
    end else if (wup_valid_i && mshr_valid_q) begin
      rr_q[mshr_addr.fields.idx] <= rr_q[mshr_addr.fields.idx] + 1'b1;
    end
  end

  // Response and miss strobes, dropped by clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_o <= 1'b0;
      miss_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= (is_load || is_store) && !clr_i;
      miss_valid_o <= load_miss && !clr_i;
    end
  end

  // Response payload
  always_ff @(posedge clk_i) begin
    resp_store_o <= is_store;
    resp_hit_o   <= hit;
    resp_data_o  <= hit_line[d1_addr_i.fields.word];
  end

endmodule

// File: dcache_l1.sv
// Top level of the L1 data cache front end with d0, two ways and d1
`timescale 1ns/1ps
`include "dcache_l1_macros.svh"

module dcache_l1 (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clr_i,
  input  logic                      lsq_valid_i,
  input  logic                      lsq_store_i,
  input  dcache_l1_pkg::paddr_u     lsq_addr_i,
  input  dcache_l1_pkg::word_t      lsq_wdata_i,
  input  dcache_l1_pkg::be_t        lsq_be_i,
  output logic                      lsq_rdy_o,
  input  logic                      l2c_valid_i,
  input  dcache_l1_pkg::line_addr_t l2c_line_addr_i,
  input  dcache_l1_pkg::line_t      l2c_line_i,
  output logic                      l2c_rdy_o,
  output logic                      resp_valid_o,
  output logic                      resp_store_o,
  output logic                      resp_hit_o,
  output dcache_l1_pkg::word_t      resp_data_o,
  output logic                      miss_valid_o,
  output dcache_l1_pkg::line_addr_t miss_line_o,
  output logic                      wup_valid_o,
  output dcache_l1_pkg::line_addr_t wup_line_o,
  output logic                      init_done_o
);

  // d0 decode to execute and result
  dcache_l1_pkg::d0_req_e                      req_type;
  dcache_l1_pkg::set_idx_t                     init_idx;
  // Shared way write port
  dcache_l1_pkg::set_idx_t                     mem_addr;
  dcache_l1_pkg::way_vec_t                     tag_we;
  dcache_l1_pkg::tag_t                         wtag;
  logic                                        wvalid;
  dcache_l1_pkg::word_vec_t [`DCACHE_WAYS-1:0] data_we;
  dcache_l1_pkg::line_t                        wline;
  // Way read data
  dcache_l1_pkg::tag_t      [`DCACHE_WAYS-1:0] way_tag;
  dcache_l1_pkg::way_vec_t                     way_valid;
  dcache_l1_pkg::line_t     [`DCACHE_WAYS-1:0] way_line;
  // d0 to d1 request
  dcache_l1_pkg::d0_req_e                      d1_req;
  dcache_l1_pkg::paddr_u                       d1_addr;
  dcache_l1_pkg::word_t                        d1_wdata;
  dcache_l1_pkg::be_t                          d1_be;
  // d1 back to d0
  logic                                        d1_st_valid;
  dcache_l1_pkg::set_idx_t                     d1_st_addr;
  dcache_l1_pkg::way_vec_t                     d1_st_way;
  dcache_l1_pkg::line_t                        d1_st_line;
  dcache_l1_pkg::word_vec_t                    d1_st_wen_words;
  logic                                        mshr_busy;
  dcache_l1_pkg::way_vec_t                     victim;

  dcache_d0_decode i_d0_decode (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lsq_valid_i   (lsq_valid_i),
    .lsq_store_i   (lsq_store_i),
    .l2c_valid_i   (l2c_valid_i),
    .d1_st_valid_i (d1_st_valid),
    .mshr_busy_i   (mshr_busy),
    .lsq_rdy_o     (lsq_rdy_o),
    .l2c_rdy_o     (l2c_rdy_o),
    .init_done_o   (init_done_o),
    .init_idx_o    (init_idx),
    .req_type_o    (req_type)
  );

  dcache_d0_execute i_d0_execute (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .clr_i             (clr_i),
    .req_type_i        (req_type),
    .init_idx_i        (init_idx),
    .lsq_addr_i        (lsq_addr_i),
    .lsq_wdata_i       (lsq_wdata_i),
    .lsq_be_i          (lsq_be_i),
    .l2c_line_addr_i   (l2c_line_addr_i),
    .l2c_line_i        (l2c_line_i),
    .d1_st_addr_i      (d1_st_addr),
    .d1_st_way_i       (d1_st_way),
    .d1_st_line_i      (d1_st_line),
    .d1_st_wen_words_i (d1_st_wen_words),
    .victim_i          (victim),
    .mem_addr_o        (mem_addr),
    .tag_we_o          (tag_we),
    .wtag_o            (wtag),
    .wvalid_o          (wvalid),
    .data_we_o         (data_we),
    .wline_o           (wline),
    .d1_req_o          (d1_req),
    .d1_addr_o         (d1_addr),
    .d1_wdata_o        (d1_wdata),
    .d1_be_o           (d1_be),
    .wup_valid_o       (wup_valid_o),
    .wup_line_o        (wup_line_o)
  );

  // One array pair per way on the shared port
  for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : gen_way
    dcache_way_sram i_way_sram (
      .clk_i     (clk_i),
      .addr_i    (mem_addr),
      .tag_we_i  (tag_we[w]),
      .wtag_i    (wtag),
      .wvalid_i  (wvalid),
      .data_we_i (data_we[w]),
      .wline_i   (wline),
      .rtag_o    (way_tag[w]),
      .rvalid_o  (way_valid[w]),
      .rline_o   (way_line[w])
    );
  end

  dcache_d1_result i_d1_result (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .clr_i             (clr_i),
    .d1_req_i          (d1_req),
    .d1_addr_i         (d1_addr),
    .d1_wdata_i        (d1_wdata),
    .d1_be_i           (d1_be),
    .way_tag_i         (way_tag),
    .way_valid_i       (way_valid),
    .way_line_i        (way_line),
    .wup_valid_i       (wup_valid_o),
    .d1_st_valid_o     (d1_st_valid),
    .d1_st_addr_o      (d1_st_addr),
    .d1_st_way_o       (d1_st_way),
    .d1_st_line_o      (d1_st_line),
    .d1_st_wen_words_o (d1_st_wen_words),
    .mshr_busy_o       (mshr_busy),
    .victim_o          (victim),
    .resp_valid_o      (resp_valid_o),
    .resp_store_o      (resp_store_o),
    .resp_hit_o        (resp_hit_o),
    .resp_data_o       (resp_data_o),
    .miss_valid_o      (miss_valid_o),
    .miss_line_o       (miss_line_o)
  );

endmodule

// File: tb_dcache_l1.sv
// Directed testbench for the L1 data cache front end with L2 line model, compare tasks, timeout
`timescale 1ns/1ps
`include "dcache_l1_macros.svh"

module tb_dcache_l1;

  localparam int MAX_CYCLES = 2000;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      clr_i;
  logic                      lsq_valid_i;
  logic                      lsq_store_i;
  dcache_l1_pkg::paddr_u     lsq_addr_i;
  dcache_l1_pkg::word_t      lsq_wdata_i;
  dcache_l1_pkg::be_t        lsq_be_i;
  logic                      lsq_rdy_o;
  logic                      l2c_valid_i;
  dcache_l1_pkg::line_addr_t l2c_line_addr_i;
  dcache_l1_pkg::line_t      l2c_line_i;
  logic                      l2c_rdy_o;
  logic                      resp_valid_o;
  logic                      resp_store_o;
  logic                      resp_hit_o;
  dcache_l1_pkg::word_t      resp_data_o;
  logic                      miss_valid_o;
  dcache_l1_pkg::line_addr_t miss_line_o;
  logic                      wup_valid_o;
  dcache_l1_pkg::line_addr_t wup_line_o;
  logic                      init_done_o;

  // L2 reference lines and expected cache contents
  integer                    seed;
  int                        cycle_cnt;
  dcache_l1_pkg::line_addr_t la [6];
  dcache_l1_pkg::line_t      l2_line [6];
  dcache_l1_pkg::line_t      shadow [6];
  // Occupants of set 5 and its round-robin bit
  int                        occ5 [2];
  int                        rr5;

  dcache_l1 UUT (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .clr_i           (clr_i),
    .lsq_valid_i     (lsq_valid_i),
    .lsq_store_i     (lsq_store_i),
    .lsq_addr_i      (lsq_addr_i),
    .lsq_wdata_i     (lsq_wdata_i),
    .lsq_be_i        (lsq_be_i),
    .lsq_rdy_o       (lsq_rdy_o),
    .l2c_valid_i     (l2c_valid_i),
    .l2c_line_addr_i (l2c_line_addr_i),
    .l2c_line_i      (l2c_line_i),
    .l2c_rdy_o       (l2c_rdy_o),
    .resp_valid_o    (resp_valid_o),
    .resp_store_o    (resp_store_o),
    .resp_hit_o      (resp_hit_o),
    .resp_data_o     (resp_data_o),
    .miss_valid_o    (miss_valid_o),
    .miss_line_o     (miss_line_o),
    .wup_valid_o     (wup_valid_o),
    .wup_line_o      (wup_line_o),
    .init_done_o     (init_done_o)
  );

  // 8 ns clock
  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  // Run limit
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("SOME TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input dcache_l1_pkg::word_t got,
                            input dcache_l1_pkg::word_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_line(input string name, input dcache_l1_pkg::line_addr_t got,
                            input dcache_l1_pkg::line_addr_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  // Word address built from the line view and the word field
  function automatic dcache_l1_pkg::paddr_u make_addr(input dcache_l1_pkg::line_addr_t line_a,
                                                      input int wo);
    dcache_l1_pkg::paddr_u a;
    a                = '0;
    a.line.line_addr = line_a;
    a.fields.word    = dcache_l1_pkg::word_off_t'(wo);
    return a;
  endfunction

  // Byte lanes with be set take the new data
  function automatic dcache_l1_pkg::word_t merge_bytes(input dcache_l1_pkg::word_t old_w,
                                                       input dcache_l1_pkg::word_t new_w,
                                                       input dcache_l1_pkg::be_t be);
    dcache_l1_pkg::word_t r;
    r = old_w;
    for (int b = 0; b < $bits(be); b++) begin
      if (be[b]) begin
        r[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return r;
  endfunction

  // Lowest empty way or else the round-robin way
  function automatic int predict_victim();
    int v;
    if (occ5[0] < 0) begin
      v = 0;
    end else if (occ5[1] < 0) begin
      v = 1;
    end else begin
      v = rr5;
    end
    return v;
  endfunction

  // Drives one LSQ request until accepted and returns 1 ns after the accept edge
  task automatic issue_lsq(input logic store, input int i, input int wo,
                           input dcache_l1_pkg::word_t wdata, input dcache_l1_pkg::be_t be);
    lsq_valid_i = 1'b1;
    lsq_store_i = store;
    lsq_addr_i  = make_addr(la[i], wo);
    lsq_wdata_i = wdata;
    lsq_be_i    = be;
    @(negedge clk_i);
    while (!lsq_rdy_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    lsq_valid_i = 1'b0;
  endtask

  task automatic lsq_access(input logic store, input int i, input int wo,
                            input dcache_l1_pkg::word_t wdata, input dcache_l1_pkg::be_t be,
                            input logic exp_hit);
    int   lat;
    logic exp_miss;
    exp_miss = !store && !exp_hit;
    issue_lsq(store, i, wo, wdata, be);
    lat = 0;
    do begin
      @(negedge clk_i);
      lat++;
      // Blocked by a store write-back or a new miss
      if (lat == 1) begin
        check_bit("lsq_rdy_o", lsq_rdy_o, !((store && exp_hit) || exp_miss));
        // Refill only held off by the store write-back
        check_bit("l2c_rdy_o", l2c_rdy_o, !(store && exp_hit));
      end
    end while (!resp_valid_o);
    if (lat != 2) begin
      $display("Response came %0d cycles after acceptance instead of 2", lat);
      abort_run();
    end
    check_bit("resp_store_o", resp_store_o, store);
    check_bit("resp_hit_o", resp_hit_o, exp_hit);
    check_bit("miss_valid_o", miss_valid_o, exp_miss);
    if (exp_miss) begin
      check_line("miss_line_o", miss_line_o, la[i]);
    end
    if (!store && exp_hit) begin
      check_word("resp_data_o", resp_data_o, shadow[i][wo]);
    end
    @(posedge clk_i);
    #1;
  endtask

  // L2 answer for line i with the wake-up seen in the accept cycle
  task automatic refill(input int i);
    l2c_valid_i     = 1'b1;
    l2c_line_addr_i = la[i];
    l2c_line_i      = l2_line[i];
    @(negedge clk_i);
    while (!l2c_rdy_o) begin
      @(negedge clk_i);
    end
    check_bit("wup_valid_o", wup_valid_o, 1'b1);
    check_line("wup_line_o", wup_line_o, la[i]);
    @(posedge clk_i);
    #1;
    l2c_valid_i = 1'b0;
    shadow[i]   = l2_line[i];
  endtask

  task automatic expect_idle_cycle(input logic exp_rdy);
    @(negedge clk_i);
    check_bit("lsq_rdy_o", lsq_rdy_o, exp_rdy);
    check_bit("resp_valid_o", resp_valid_o, 1'b0);
    check_bit("miss_valid_o", miss_valid_o, 1'b0);
    @(posedge clk_i);
    #1;
  endtask

  // Miss, refill and tracking of one line of set 5
  task automatic fill_set5(input int i);
    int v;
    lsq_access(1'b0, i, 1, '0, '0, 1'b0);
    v = predict_victim();
    refill(i);
    occ5[v] = i;
    rr5     = 1 - rr5;
  endtask

  task automatic init_and_first_miss();
    int sweep;
    sweep = 0;
    @(negedge clk_i);
    check_bit("resp_valid_o", resp_valid_o, 1'b0);
    check_bit("miss_valid_o", miss_valid_o, 1'b0);
    check_bit("wup_valid_o", wup_valid_o, 1'b0);
    while (!init_done_o) begin
      check_bit("lsq_rdy_o", lsq_rdy_o, 1'b0);
      check_bit("l2c_rdy_o", l2c_rdy_o, 1'b0);
      sweep++;
      @(negedge clk_i);
    end
    // One set swept per cycle
    if (sweep != `DCACHE_SETS) begin
      $display("Init sweep took %0d cycles instead of %0d", sweep, `DCACHE_SETS);
      abort_run();
    end
    check_bit("lsq_rdy_o", lsq_rdy_o, 1'b1);
    check_bit("l2c_rdy_o", l2c_rdy_o, 1'b1);
    @(posedge clk_i);
    #1;
    lsq_access(1'b0, 0, 1, '0, '0, 1'b0);
    expect_idle_cycle(1'b0);
  endtask

  task automatic refill_and_reload();
    refill(0);
    expect_idle_cycle(1'b1);
    lsq_access(1'b0, 0, 3, '0, '0, 1'b1);
  endtask

  task automatic store_merge();
    lsq_access(1'b1, 0, 2, 32'ha5a5_5a5a, 4'b0110, 1'b1);
    shadow[0][2] = merge_bytes(shadow[0][2], 32'ha5a5_5a5a, 4'b0110);
    lsq_access(1'b0, 0, 2, '0, '0, 1'b1);
    // No-write-allocate store miss
    lsq_access(1'b1, 1, 1, 32'hdead_beef, 4'b1111, 1'b0);
    lsq_access(1'b0, 1, 1, '0, '0, 1'b0);
    refill(1);
    lsq_access(1'b0, 1, 1, '0, '0, 1'b1);
  endtask

  task automatic set_eviction();
    int evicted;
    fill_set5(2);
    fill_set5(3);
    lsq_access(1'b0, 2, 0, '0, '0, 1'b1);
    lsq_access(1'b0, 3, 3, '0, '0, 1'b1);
    evicted = occ5[predict_victim()];
    fill_set5(4);
    lsq_access(1'b0, occ5[0], 2, '0, '0, 1'b1);
    lsq_access(1'b0, occ5[1], 2, '0, '0, 1'b1);
    // Reload of the evicted line must miss
    fill_set5(evicted);
  endtask

  task automatic back_to_back_loads();
    int sel;
    for (int j = 0; j < 6; j++) begin
      if (j < 4) begin
        sel         = (j == 2) ? 1 : 0;
        lsq_valid_i = 1'b1;
        lsq_store_i = 1'b0;
        lsq_addr_i  = make_addr(la[sel], j);
      end else begin
        lsq_valid_i = 1'b0;
      end
      @(negedge clk_i);
      if (j < 4) begin
        check_bit("lsq_rdy_o", lsq_rdy_o, 1'b1);
      end
      // Load j-2 answers in this cycle
      check_bit("resp_valid_o", resp_valid_o, j >= 2);
      if (j >= 2) begin
        sel = (j == 4) ? 1 : 0;
        check_bit("resp_hit_o", resp_hit_o, 1'b1);
        check_word("resp_data_o", resp_data_o, shadow[sel][j-2]);
      end
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic clear_pending_miss();
    lsq_access(1'b0, 5, 0, '0, '0, 1'b0);
    expect_idle_cycle(1'b0);
    clr_i = 1'b1;
    @(posedge clk_i);
    #1;
    clr_i = 1'b0;
    expect_idle_cycle(1'b1);
    // Clear while the load sits in d1
    issue_lsq(1'b0, 5, 1, '0, '0);
    clr_i = 1'b1;
    @(posedge clk_i);
    #1;
    clr_i = 1'b0;
    repeat (3) begin
      expect_idle_cycle(1'b1);
    end
  endtask

  initial begin
    cycle_cnt       = 0;
    seed            = 85;
    rst_ni          = 1'b0;
    clr_i           = 1'b0;
    lsq_valid_i     = 1'b0;
    lsq_store_i     = 1'b0;
    lsq_addr_i      = '0;
    lsq_wdata_i     = '0;
    lsq_be_i        = '0;
    l2c_valid_i     = 1'b0;
    l2c_line_addr_i = '0;
    l2c_line_i      = '0;
    // Tag in the upper bits and set in the low nibble
    la[0] = 28'h0000101;
    la[1] = 28'h0000202;
    la[2] = 28'h0000515;
    la[3] = 28'h0000525;
    la[4] = 28'h0000535;
    la[5] = 28'h0000707;
    for (int i = 0; i < 6; i++) begin
      for (int w = 0; w < `DCACHE_LINE_WORDS; w++) begin
        l2_line[i][w] = $random(seed);
      end
      shadow[i] = '0;
    end
    occ5[0] = -1;
    occ5[1] = -1;
    rr5     = 0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    init_and_first_miss();
    refill_and_reload();
    store_merge();
    set_eviction();
    back_to_back_loads();
    clear_pending_miss();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: dcache_l1.f
+incdir+.
dcache_l1_pkg.sv
dcache_way_sram.sv
dcache_d0_decode.sv
dcache_d0_execute.sv
dcache_d1_result.sv
dcache_l1.sv
tb_dcache_l1.sv

// File: Bender.yml
package:
  name: dcache_l1

export_include_dirs:
  - .

sources:
  - dcache_l1_pkg.sv
  - dcache_way_sram.sv
  - dcache_d0_decode.sv
  - dcache_d0_execute.sv
  - dcache_d1_result.sv
  - dcache_l1.sv
  - target: simulation
    files:
      - tb_dcache_l1.sv
